// File: rtl/cpu_pkg.sv
// Shared definitions for the decode and execute slice.
// Holds the MIPS opcode and function codes, ALU and exception types,
// and the instruction word views used by the decoder.

package cpu_pkg;

  // Widths
  localparam int data_w     = 32;
  localparam int reg_addr_w = 5;

  //////////////////////////////////////////////////////////////////////
  // Primary opcodes
  //////////////////////////////////////////////////////////////////////
  localparam logic [5:0] op_special = 6'h00;
  localparam logic [5:0] op_addi    = 6'h08;
  localparam logic [5:0] op_addiu   = 6'h09;
  localparam logic [5:0] op_slti    = 6'h0a;
  localparam logic [5:0] op_sltiu   = 6'h0b;
  localparam logic [5:0] op_andi    = 6'h0c;
  localparam logic [5:0] op_ori     = 6'h0d;
  localparam logic [5:0] op_xori    = 6'h0e;
  localparam logic [5:0] op_lui     = 6'h0f;

  // Function codes under op_special
  localparam logic [5:0] fn_sll  = 6'h00;
  localparam logic [5:0] fn_srl  = 6'h02;
  localparam logic [5:0] fn_sra  = 6'h03;
  localparam logic [5:0] fn_add  = 6'h20;
  localparam logic [5:0] fn_addu = 6'h21;
  localparam logic [5:0] fn_sub  = 6'h22;
  localparam logic [5:0] fn_subu = 6'h23;
  localparam logic [5:0] fn_and  = 6'h24;
  localparam logic [5:0] fn_or   = 6'h25;
  localparam logic [5:0] fn_xor  = 6'h26;
  localparam logic [5:0] fn_nor  = 6'h27;
  localparam logic [5:0] fn_slt  = 6'h2a;
  localparam logic [5:0] fn_sltu = 6'h2b;

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_t;

  // One flag per exception source
  typedef struct packed {
    logic rsv_instr;
    logic ovf;
  } exc_t;

  typedef enum logic [1:0] {dst_rd, dst_rt, dst_none} dst_sel_t;

  // Same 32-bit word read as R-type or I-type
  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
    } i;
  } instr_u;

endpackage

// File: rtl/pipe_regs_if.sv
// ID/EX pipeline register bundle.
// The decoder fills the id_* side, id_ex_reg holds the exe_* copies
// and the execute stage consumes them.

`timescale 1ns/1ps

interface pipe_regs_if (
  input logic clk,
  input logic reset
);
  import cpu_pkg::*;

  // Decode side
  logic              id_valid;
  logic [data_w-1:0] id_bus_a;
  logic [data_w-1:0] id_bus_b;
  logic [data_w-1:0] id_imm32;
  logic [data_w-1:0] id_pc_add4;
  logic [4:0]        id_rs;
  logic [4:0]        id_rt;
  logic [4:0]        id_dst;
  alu_op_t           id_alu_op;
  logic              id_use_imm;
  logic              id_signed_ovf;
  exc_t              id_exc;

  // Execute side
  logic              exe_valid;
  logic [data_w-1:0] exe_bus_a;
  logic [data_w-1:0] exe_bus_b;
  logic [data_w-1:0] exe_imm32;
  logic [data_w-1:0] exe_pc_add4;
  logic [4:0]        exe_rs;
  logic [4:0]        exe_rt;
  logic [4:0]        exe_dst;
  alu_op_t           exe_alu_op;
  logic              exe_use_imm;
  logic              exe_signed_ovf;
  exc_t              exe_exc;
  logic [4:0]        exe_shamt;

  modport id (
    output id_valid, id_bus_a, id_bus_b, id_imm32, id_pc_add4, id_rs, id_rt,
    output id_dst, id_alu_op, id_use_imm, id_signed_ovf, id_exc
  );

  modport id_exe (
    input  clk, reset,
    input  id_valid, id_bus_a, id_bus_b, id_imm32, id_pc_add4, id_rs, id_rt,
    input  id_dst, id_alu_op, id_use_imm, id_signed_ovf, id_exc,
    output exe_valid, exe_bus_a, exe_bus_b, exe_imm32, exe_pc_add4, exe_rs,
    output exe_rt, exe_dst, exe_alu_op, exe_use_imm, exe_signed_ovf, exe_exc,
    output exe_shamt
  );

  modport exe (
    input clk, reset,
    input exe_valid, exe_bus_a, exe_bus_b, exe_imm32, exe_pc_add4, exe_rs,
    input exe_rt, exe_dst, exe_alu_op, exe_use_imm, exe_signed_ovf, exe_exc,
    input exe_shamt
  );

endinterface

// File: rtl/reg_file.sv
// General purpose register file, 2 read ports and 1 write port.
// Register 0 reads as zero; a write in the same cycle bypasses to the reads.

`timescale 1ns/1ps

module reg_file #(
  parameter int data_w = 32
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
  input  logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
  output logic [data_w-1:0]             rs_data,
  output logic [data_w-1:0]             rt_data,
  input  logic                          we,
  input  logic [cpu_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [data_w-1:0]             wr_data
);
  import cpu_pkg::*;

  // Only 1..31 are storage
  logic [data_w-1:0] regs [1:(1 << reg_addr_w) - 1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < (1 << reg_addr_w); i++) begin
        regs[i] <= '0;
      end
    end else if (we && wr_addr != '0) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write-through so WB and ID can share a cycle
  assign rs_data = (rs_addr == '0) ? '0 :
                   (we && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 :
                   (we && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

// File: rtl/decoder.sv
// Decode stage, purely combinational.
// Turns the instruction word into ALU controls, operands, the extended
// immediate and the destination register, and drives the ID/EX inputs.

`timescale 1ns/1ps

module decoder (
  input  cpu_pkg::instr_u instr,
  input  logic            instr_valid,
  input  logic [31:0]     pc_add4,
  output logic [4:0]      rs_addr,
  output logic [4:0]      rt_addr,
  input  logic [31:0]     rs_data,
  input  logic [31:0]     rt_data,
  pipe_regs_if.id         port
);
  import cpu_pkg::*;

  alu_op_t    alu_op;
  dst_sel_t   dst_sel;
  logic       use_imm;
  logic       signed_ovf;
  logic       zero_ext;
  logic       rsv;
  logic [4:0] dst;

  //////////////////////////////////////////////////////////////////////
  // Opcode and function decode
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    alu_op     = alu_add;
    dst_sel    = dst_rt;
    use_imm    = 1'b1;
    signed_ovf = 1'b0;
    zero_ext   = 1'b0;
    rsv        = 1'b0;
    case (instr.r.opcode)
      op_special: begin
        dst_sel = dst_rd;
        use_imm = 1'b0;
        case (instr.r.funct)
          fn_add:  signed_ovf = 1'b1;
          fn_addu: alu_op = alu_add;
          fn_sub: begin
            alu_op     = alu_sub;
            signed_ovf = 1'b1;
          end
          fn_subu: alu_op = alu_sub;
          fn_and:  alu_op = alu_and;
          fn_or:   alu_op = alu_or;
          fn_xor:  alu_op = alu_xor;
          fn_nor:  alu_op = alu_nor;
          fn_slt:  alu_op = alu_slt;
          fn_sltu: alu_op = alu_sltu;
          fn_sll:  alu_op = alu_sll;
          fn_srl:  alu_op = alu_srl;
          fn_sra:  alu_op = alu_sra;
          default: rsv = 1'b1;
        endcase
      end
      op_addi:  signed_ovf = 1'b1;
      op_addiu: alu_op = alu_add;
      op_slti:  alu_op = alu_slt;
      op_sltiu: alu_op = alu_sltu;
      op_andi: begin
        alu_op   = alu_and;
        zero_ext = 1'b1;
      end
      op_ori: begin
        alu_op   = alu_or;
        zero_ext = 1'b1;
      end
      op_xori: begin
        alu_op   = alu_xor;
        zero_ext = 1'b1;
      end
      op_lui:   alu_op = alu_lui;
      default:  rsv = 1'b1;
    endcase
    // Nothing gets written for an unknown encoding
    if (rsv) begin
      dst_sel = dst_none;
    end
  end

  // Bubble slots never target a register
  always_comb begin
    case (dst_sel)
      dst_rd:  dst = instr.r.rd;
      dst_rt:  dst = instr.i.rt;
      default: dst = 5'd0;
    endcase
    if (!instr_valid) begin
      dst = 5'd0;
    end
  end

  assign rs_addr = instr.r.rs;
  assign rt_addr = instr.r.rt;

  //////////////////////////////////////////////////////////////////////
  // ID/EX inputs
  //////////////////////////////////////////////////////////////////////
  assign port.id_valid      = instr_valid;
  assign port.id_bus_a      = rs_data;
  assign port.id_bus_b      = rt_data;
  // R-type keeps shamt in bits 10:6 either way
  assign port.id_imm32      = zero_ext ? {16'h0000, instr.i.imm}
                                       : {{16{instr.i.imm[15]}}, instr.i.imm};
  assign port.id_pc_add4    = pc_add4;
  assign port.id_rs         = instr.r.rs;
  assign port.id_rt         = instr.r.rt;
  assign port.id_dst        = dst;
  assign port.id_alu_op     = alu_op;
  assign port.id_use_imm    = use_imm;
  assign port.id_signed_ovf = signed_ovf;
  // Overflow is only known in execute
  assign port.id_exc        = '{rsv_instr: instr_valid & rsv, ovf: 1'b0};

endmodule

// File: rtl/id_ex_reg.sv
// ID/EX pipeline register.
// Copies the decode bundle every cycle; the shift amount is split out
// of the immediate on the way through.

`timescale 1ns/1ps

module id_ex_reg (
  pipe_regs_if.id_exe port
);
  import cpu_pkg::*;

  always_ff @(posedge port.clk) begin
    if (port.reset) begin
      port.exe_valid      <= 1'b0;
      port.exe_bus_a      <= {data_w{1'b0}};
      port.exe_bus_b      <= {data_w{1'b0}};
      port.exe_imm32      <= {data_w{1'b0}};
      port.exe_pc_add4    <= {data_w{1'b0}};
      port.exe_rs         <= 5'd0;
      port.exe_rt         <= 5'd0;
      port.exe_dst        <= 5'd0;
      port.exe_alu_op     <= alu_add;
      port.exe_use_imm    <= 1'b0;
      port.exe_signed_ovf <= 1'b0;
      port.exe_exc        <= exc_t'(0);
      port.exe_shamt      <= 5'd0;
    end else begin
      port.exe_valid      <= port.id_valid;
      port.exe_bus_a      <= port.id_bus_a;
      port.exe_bus_b      <= port.id_bus_b;
      port.exe_imm32      <= port.id_imm32;
      port.exe_pc_add4    <= port.id_pc_add4;
      port.exe_rs         <= port.id_rs;
      port.exe_rt         <= port.id_rt;
      port.exe_dst        <= port.id_dst;
      port.exe_alu_op     <= port.id_alu_op;
      port.exe_use_imm    <= port.id_use_imm;
      port.exe_signed_ovf <= port.id_signed_ovf;
      port.exe_exc        <= port.id_exc;
      // shamt field of the R-type word
      port.exe_shamt      <= port.id_imm32[10:6];
    end
  end

endmodule

// File: rtl/exe_stage.sv
// Execute stage with the EX/WB output register.
// Forwards from its own output register, runs the ALU, checks signed
// overflow and registers the write-back and status for the top outputs.

`timescale 1ns/1ps

module exe_stage (
  pipe_regs_if.exe     port,
  output logic         wb_we,
  output logic [4:0]   wb_reg,
  output logic [31:0]  wb_data,
  output logic         out_valid,
  output logic [31:0]  out_pc_add4,
  output cpu_pkg::exc_t out_exc
);
  import cpu_pkg::*;

  logic [data_w-1:0] op_a;
  logic [data_w-1:0] rt_val;
  logic [data_w-1:0] op_b;
  logic [data_w-1:0] sum;
  logic [data_w-1:0] diff;
  logic [data_w-1:0] result;
  logic              ovf;
  logic              fwd_a;
  logic              fwd_b;
  logic              we_nxt;
  exc_t              exc_nxt;

  //////////////////////////////////////////////////////////////////////
  // Operand forwarding from EX/WB
  //////////////////////////////////////////////////////////////////////
  assign fwd_a = wb_we && (wb_reg != 5'd0) && (wb_reg == port.exe_rs);
  assign fwd_b = wb_we && (wb_reg != 5'd0) && (wb_reg == port.exe_rt);

  assign op_a   = fwd_a ? wb_data : port.exe_bus_a;
  assign rt_val = fwd_b ? wb_data : port.exe_bus_b;
  assign op_b   = port.exe_use_imm ? port.exe_imm32 : rt_val;

  // ALU
  assign sum  = op_a + op_b;
  assign diff = op_a - op_b;

  always_comb begin
    case (port.exe_alu_op)
      alu_add:  result = sum;
      alu_sub:  result = diff;
      alu_and:  result = op_a & op_b;
      alu_or:   result = op_a | op_b;
      alu_xor:  result = op_a ^ op_b;
      alu_nor:  result = ~(op_a | op_b);
      alu_slt:  result = {31'd0, $signed(op_a) < $signed(op_b)};
      alu_sltu: result = {31'd0, op_a < op_b};
      // Shifts work on rt and not on the immediate
      alu_sll:  result = rt_val << port.exe_shamt;
      alu_srl:  result = rt_val >> port.exe_shamt;
      alu_sra:  result = $unsigned($signed(rt_val) >>> port.exe_shamt);
      alu_lui:  result = {port.exe_imm32[15:0], 16'h0000};
      default:  result = sum;
    endcase
  end

  // Signed overflow from the operand and result sign bits
  always_comb begin
    if (port.exe_alu_op == alu_sub) begin
      ovf = (op_a[31] != op_b[31]) && (diff[31] != op_a[31]);
    end else begin
      ovf = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);
    end
    ovf = ovf && port.exe_signed_ovf && port.exe_valid;
  end

  assign exc_nxt = '{rsv_instr: port.exe_exc.rsv_instr, ovf: ovf};
  assign we_nxt  = port.exe_valid && (port.exe_dst != 5'd0) &&
                   !exc_nxt.rsv_instr && !exc_nxt.ovf;

  //////////////////////////////////////////////////////////////////////
  // EX/WB output register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge port.clk) begin
    if (port.reset) begin
      wb_we     <= 1'b0;
      wb_reg    <= 5'd0;
      out_valid <= 1'b0;
      out_exc   <= exc_t'(0);
    end else begin
      wb_we     <= we_nxt;
      wb_reg    <= port.exe_dst;
      out_valid <= port.exe_valid;
      out_exc   <= exc_nxt;
    end
  end

  // Payload
  always_ff @(posedge port.clk) begin
    wb_data     <= result;
    out_pc_add4 <= port.exe_pc_add4;
  end

endmodule

// File: rtl/id_exe_core.sv
// Decode and execute slice of the integer pipeline.
// One instruction per cycle in; results come out two cycles later and
// are written back into the register file from the same register.

`timescale 1ns/1ps

module id_exe_core (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           instr_valid,
  input  logic [31:0]                    instr,
  input  logic [31:0]                    pc_add4,
  output logic                           out_valid,
  output logic [31:0]                    out_pc_add4,
  output cpu_pkg::exc_t                  out_exc,
  output logic                           out_we,
  output logic [cpu_pkg::reg_addr_w-1:0] out_reg,
  output logic [cpu_pkg::data_w-1:0]     out_data
);
  import cpu_pkg::*;

  logic [reg_addr_w-1:0] rs_addr;
  logic [reg_addr_w-1:0] rt_addr;
  logic [data_w-1:0]     rs_data;
  logic [data_w-1:0]     rt_data;
  // Write-back straight from EX/WB
  logic                  wb_we;
  logic [reg_addr_w-1:0] wb_reg;
  logic [data_w-1:0]     wb_data;

  pipe_regs_if pipe (
    .clk   (clk),
    .reset (reset)
  );

  reg_file #(
    .data_w (data_w)
  ) i_reg_file (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .we      (wb_we),
    .wr_addr (wb_reg),
    .wr_data (wb_data)
  );

  decoder i_decoder (
    .instr       (instr),
    .instr_valid (instr_valid),
    .pc_add4     (pc_add4),
    .rs_addr     (rs_addr),
    .rt_addr     (rt_addr),
    .rs_data     (rs_data),
    .rt_data     (rt_data),
    .port        (pipe.id)
  );

  id_ex_reg i_id_ex_reg (
    .port (pipe.id_exe)
  );

  exe_stage i_exe_stage (
    .port        (pipe.exe),
    .wb_we       (wb_we),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .out_valid   (out_valid),
    .out_pc_add4 (out_pc_add4),
    .out_exc     (out_exc)
  );

  assign out_we   = wb_we;
  assign out_reg  = wb_reg;
  assign out_data = wb_data;

endmodule

// File: tests/tb_id_exe_core.sv
// Testbench for the decode and execute slice.
// Issues one instruction per cycle and checks every output slot two
// cycles later against a register-file model kept in program order.

`timescale 1ns/1ps

module tb_id_exe_core;
  import cpu_pkg::*;

  // Expected output of one issue slot
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [1:0]  exc;
    logic        we;
    logic [4:0]  rd;
    logic [31:0] data;
    logic        chk;
  } exp_t;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc_add4;
  logic        out_valid;
  logic [31:0] out_pc_add4;
  exc_t        out_exc;
  logic        out_we;
  logic [4:0]  out_reg;
  logic [31:0] out_data;

  logic [31:0] model_regs [0:31];
  exp_t        exp_q [$];
  integer      seed;
  logic [31:0] pc_next;
  int          errors;
  int          checks;
  int          test_no;
  int          err_mark;
  int          chk_mark;
  logic        timed_out;

  // Opcode pools for the random stream
  logic [5:0] r_fns [0:12] = '{fn_addu, fn_add, fn_subu, fn_sub, fn_and, fn_or, fn_xor,
                               fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
  logic [5:0] i_ops [0:7]  = '{op_addiu, op_addi, op_andi, op_ori, op_xori, op_slti,
                               op_sltiu, op_lui};

  id_exe_core i_id_exe_core (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc_add4     (pc_add4),
    .out_valid   (out_valid),
    .out_pc_add4 (out_pc_add4),
    .out_exc     (out_exc),
    .out_we      (out_we),
    .out_reg     (out_reg),
    .out_data    (out_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////
  task automatic model_step(input logic valid, input logic [31:0] w, input logic [31:0] pc,
                            output exp_t e);
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] bop;
    logic [31:0] simm;
    logic [31:0] r;
    logic [32:0] wide;
    logic        rsv;
    logic        ovf_chk;
    logic        is_sub;
    logic        ovf;
    rs      = w[25:21];
    rt      = w[20:16];
    a       = model_regs[rs];
    b       = model_regs[rt];
    simm    = {{16{w[15]}}, w[15:0]};
    rsv     = 1'b0;
    ovf_chk = 1'b0;
    is_sub  = 1'b0;
    r       = 32'd0;
    if (w[31:26] == op_special) begin
      dst = w[15:11];
      bop = b;
      case (w[5:0])
        fn_add: begin
          r       = a + b;
          ovf_chk = 1'b1;
        end
        fn_addu: r = a + b;
        fn_sub: begin
          r       = a - b;
          ovf_chk = 1'b1;
          is_sub  = 1'b1;
        end
        fn_subu: r = a - b;
        fn_and:  r = a & b;
        fn_or:   r = a | b;
        fn_xor:  r = a ^ b;
        fn_nor:  r = ~(a | b);
        fn_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        fn_sltu: r = (a < b) ? 32'd1 : 32'd0;
        // Shifts take rt and the shamt field
        fn_sll:  r = b << w[10:6];
        fn_srl:  r = b >> w[10:6];
        fn_sra:  r = $signed(b) >>> w[10:6];
        default: rsv = 1'b1;
      endcase
    end else begin
      dst = rt;
      bop = simm;
      case (w[31:26])
        op_addi: begin
          r       = a + simm;
          ovf_chk = 1'b1;
        end
        op_addiu: r = a + simm;
        op_slti:  r = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
        op_sltiu: r = (a < simm) ? 32'd1 : 32'd0;
        // Logic immediates are zero-extended
        op_andi:  r = a & {16'h0000, w[15:0]};
        op_ori:   r = a | {16'h0000, w[15:0]};
        op_xori:  r = a ^ {16'h0000, w[15:0]};
        op_lui:   r = {w[15:0], 16'h0000};
        default:  rsv = 1'b1;
      endcase
    end
    // 33-bit signed result that no longer fits in 32 bits
    if (is_sub) begin
      wide = {a[31], a} - {bop[31], bop};
    end else begin
      wide = {a[31], a} + {bop[31], bop};
    end
    ovf = (wide[32] != wide[31]) && ovf_chk && valid;
    if (rsv || !valid) begin
      dst = 5'd0;
    end
    e.valid = valid;
    e.pc    = pc;
    e.exc   = {valid & rsv, ovf};
    e.we    = valid && !rsv && !ovf && (dst != 5'd0);
    e.rd    = dst;
    e.data  = r;
    e.chk   = valid && !rsv && !ovf;
    if (e.we) begin
      model_regs[dst] = r;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checking and issue
  ////////////////////////////////////////////////////////////////////
  task report_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    errors++;
  endtask

  task check_out(input exp_t e);
    checks++;
    if (out_valid !== e.valid) begin
      report_error($sformatf("out_valid %b, expected %b", out_valid, e.valid));
    end
    if (out_exc !== e.exc) begin
      report_error($sformatf("out_exc %b, expected %b (pc %h)", out_exc, e.exc, e.pc));
    end
    if (out_we !== e.we) begin
      report_error($sformatf("out_we %b, expected %b (pc %h)", out_we, e.we, e.pc));
    end
    if (e.valid && out_pc_add4 !== e.pc) begin
      report_error($sformatf("out_pc_add4 %h, expected %h", out_pc_add4, e.pc));
    end
    if (e.valid && out_reg !== e.rd) begin
      report_error($sformatf("out_reg %0d, expected %0d (pc %h)", out_reg, e.rd, e.pc));
    end
    if (e.chk && out_data !== e.data) begin
      report_error($sformatf("out_data %h, expected %h (pc %h)", out_data, e.data, e.pc));
    end
  endtask

  // One slot per cycle with outputs checked mid-cycle two slots later
  task issue(input logic valid, input logic [31:0] w);
    exp_t e;
    @(posedge clk);
    #1;
    instr_valid = valid;
    instr       = w;
    pc_add4     = pc_next;
    model_step(valid, w, pc_next, e);
    exp_q.push_back(e);
    pc_next = pc_next + 32'd4;
    @(negedge clk);
    if (exp_q.size() > 2) begin
      check_out(exp_q.pop_front());
    end
  endtask

  function automatic logic pending_valid();
    foreach (exp_q[i]) begin
      if (exp_q[i].valid) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Bubbles until every issued instruction has been checked
  task drain();
    int cnt;
    cnt = 0;
    while (pending_valid() && !timed_out) begin
      if (cnt >= 8) begin
        $display("timeout: pipeline did not drain within 8 cycles");
        errors++;
        timed_out = 1'b1;
      end else begin
        issue(1'b0, 32'd0);
        cnt++;
      end
    end
  endtask

  task wait_reset_clear();
    int cnt;
    cnt = 0;
    checks++;
    while ((out_valid !== 1'b0 || out_we !== 1'b0 || out_exc !== 2'b00) && !timed_out) begin
      if (cnt >= 4) begin
        $display("timeout: outputs did not clear after reset");
        errors++;
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
        cnt++;
      end
    end
  endtask

  // or $0, rs, $0 shows a register on out_data without writing
  task read_back(input int lo, input int hi);
    for (int r = lo; r <= hi; r++) begin
      issue(1'b1, {op_special, r[4:0], 5'd0, 5'd0, 5'd0, fn_or});
    end
  endtask

  // Mostly 0..4 so dependences are frequent
  task pick_reg(output logic [4:0] r);
    int v;
    v = $random(seed) & 7;
    if (v < 5) begin
      r = v[4:0];
    end else begin
      r = $random(seed);
    end
  endtask

  task gen_instr(output logic [31:0] w);
    int         sel;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] sh;
    logic [15:0] imm;
    sel = $unsigned($random(seed)) % 21;
    pick_reg(rs);
    pick_reg(rt);
    pick_reg(rd);
    sh  = $random(seed);
    imm = $random(seed);
    if (sel < 13) begin
      w = {op_special, rs, rt, rd, sh, r_fns[sel]};
    end else begin
      w = {i_ops[sel-13], rs, rt, imm};
    end
  endtask

  task start_test();
    test_no++;
    err_mark = errors;
    chk_mark = checks;
  endtask

  task end_test(input string name);
    drain();
    $display("test %0d %s: %0d checks, %0d failed", test_no, name,
             checks - chk_mark, errors - err_mark);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////
  initial begin
    logic [31:0] w;
    logic [4:0]  hist [0:1];
    logic [4:0]  src;
    logic [4:0]  dst;
    logic [4:0]  rs;
    logic [4:0]  rt;
    int          kind;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = 32'd0;
    pc_add4     = 32'd0;
    seed        = 32'h46af;
    pc_next     = 32'h0000_0004;
    errors      = 0;
    checks      = 0;
    test_no     = 0;
    timed_out   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;

    // Reset state and a cleared register file
    start_test();
    wait_reset_clear();
    read_back(0, 31);
    end_test("reset");

    start_test();
    for (int i = 0; i < 300; i++) begin
      gen_instr(w);
      issue(1'b1, w);
    end
    end_test("random alu");

    // Each source is the destination one or two slots back
    start_test();
    hist[0] = 5'd1;
    hist[1] = 5'd2;
    for (int i = 0; i < 80; i++) begin
      src  = hist[$random(seed) & 1];
      dst  = 5'd1 + ($unsigned($random(seed)) % 4);
      pick_reg(rs);
      kind = $random(seed) & 3;
      case (kind)
        0:       w = {op_special, src, rs, dst, 5'd0, fn_addu};
        1:       w = {op_addiu, src, dst, 16'($random(seed))};
        2:       w = {op_special, 5'd0, src, dst, 5'($random(seed)), fn_sll};
        default: w = {op_special, rs, src, dst, 5'd0, fn_subu};
      endcase
      hist[1] = hist[0];
      hist[0] = dst;
      issue(1'b1, w);
    end
    end_test("dependences");

    // Edge operands followed by trapping and wrapping forms side by side
    start_test();
    issue(1'b1, {op_lui, 5'd0, 5'd1, 16'h7fff});
    issue(1'b1, {op_ori, 5'd1, 5'd1, 16'hffff});
    issue(1'b1, {op_addiu, 5'd0, 5'd2, 16'h0001});
    issue(1'b1, {op_lui, 5'd0, 5'd3, 16'h8000});
    issue(1'b1, {op_special, 5'd1, 5'd2, 5'd4, 5'd0, fn_add});
    issue(1'b1, {op_special, 5'd1, 5'd2, 5'd4, 5'd0, fn_addu});
    issue(1'b1, {op_addi, 5'd1, 5'd5, 16'h0001});
    issue(1'b1, {op_addiu, 5'd1, 5'd5, 16'h0001});
    issue(1'b1, {op_special, 5'd3, 5'd2, 5'd6, 5'd0, fn_sub});
    issue(1'b1, {op_special, 5'd3, 5'd2, 5'd6, 5'd0, fn_subu});
    issue(1'b1, {op_addi, 5'd3, 5'd7, 16'hffff});
    issue(1'b1, {op_addiu, 5'd3, 5'd7, 16'hffff});
    read_back(4, 7);
    end_test("overflow");

    start_test();
    for (int i = 0; i < 60; i++) begin
      pick_reg(rs);
      pick_reg(rt);
      dst  = 5'd1 + ($unsigned($random(seed)) % 8);
      kind = $random(seed) & 3;
      case (kind)
        0: begin
          w = $random(seed);
          issue(1'b0, w);
        end
        1: issue(1'b1, {6'h10 + 6'($unsigned($random(seed)) % 8), rs, dst, 16'h1234});
        2: issue(1'b1, {op_special, rs, rt, dst, 5'd0, 6'h30 + 6'($random(seed) & 7)});
        default: issue(1'b1, {op_addiu, rs, 5'd0, 16'($random(seed))});
      endcase
    end
    read_back(0, 31);
    end_test("reserved and bubbles");

    $display("tests: %0d  checks: %0d  errors: %0d", test_no, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: src.f
rtl/cpu_pkg.sv
rtl/pipe_regs_if.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/id_ex_reg.sv
rtl/exe_stage.sv
rtl/id_exe_core.sv
tests/tb_id_exe_core.sv
